// ==== hdl/usb_rx_pkg.sv ====
`default_nettype none

package usb_rx_pkg;

	// one byte of the incoming stream or of the payload.
	typedef logic [7:0] byte_t;

	// address into the 64-byte receive buffer.
	typedef logic [5:0] buf_addr_t;

	// byte count in the buffer, 0 to 64 inclusive.
	typedef logic [6:0] buf_count_t;

	localparam int unsigned BUF_DEPTH = 64;

	// sync, pid, endpoint, three header bytes and the crc.
	localparam int unsigned MIN_FRAME_LEN = 7;

	typedef enum logic [1:0]
	{
		IDLE,
		RECEIVE,
		VERDICT
	} dec_state_t;

endpackage

`default_nettype wire

// ==== hdl/crc8_atm_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc8_atm_calc
(
	input  wire                 clk,
	input  wire                 N_RST_DECODER,
	input  wire                 clear,
	input  wire                 en,
	input  usb_rx_pkg::byte_t   d,
	output usb_rx_pkg::byte_t   crc
);

	import usb_rx_pkg::*;

	byte_t crc_next;

	// one bit of the polynomial 07h division, msb first.
	function automatic byte_t crc_step(input byte_t c, input logic b);
		logic fb;
		fb = c[7] ^ b;
		return fb ? ({c[6:0], 1'b0} ^ 8'h07) : {c[6:0], 1'b0};
	endfunction

	always_comb
	begin
		crc_next = crc;
		crc_next = crc_step(crc_next, d[7]);
		crc_next = crc_step(crc_next, d[6]);
		crc_next = crc_step(crc_next, d[5]);
		crc_next = crc_step(crc_next, d[4]);
		crc_next = crc_step(crc_next, d[3]);
		crc_next = crc_step(crc_next, d[2]);
		crc_next = crc_step(crc_next, d[1]);
		crc_next = crc_step(crc_next, d[0]);
	end

	always_ff @(posedge clk or negedge N_RST_DECODER)
	begin
		if (!N_RST_DECODER)
			crc <= '0;
		else if (clear)
			crc <= '0;
		else if (en)
			crc <= crc_next;
	end

endmodule

`default_nettype wire

// ==== hdl/frame_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_decoder
(
	input  wire                 clk,
	input  wire                 N_RST_DECODER,
	input  wire                 in_valid,
	input  usb_rx_pkg::byte_t   in_data,
	input  wire                 buf_full,
	output logic                wr_en,
	output usb_rx_pkg::byte_t   wr_data,
	output logic                commit,
	output logic                rewind,
	output logic                frame_ok,
	output logic                frame_bad
);

	import usb_rx_pkg::*;

	dec_state_t state;
	dec_state_t state_next;

	logic [7:0] byte_cnt;
	logic       accept;
	logic       kept;
	logic       overflow;
	logic       frame_end;
	logic       frame_good;
	logic       verdict_ok;
	logic       crc_clear;
	byte_t      crc;

	// a byte is taken on every valid cycle outside the verdict cycle.
	assign accept = in_valid && (state != VERDICT);

	// the endpoint byte and everything from byte 6 on, crc included.
	assign kept = accept && ((byte_cnt == 8'd2) || (byte_cnt >= 8'd6));

	assign wr_en   = kept;
	assign wr_data = in_data;

	assign frame_end  = (state == RECEIVE) && !in_valid;
	assign frame_good = (crc == 8'h00) && (byte_cnt >= MIN_FRAME_LEN) && !overflow;

	// the buffer acts on these at the edge that closes the first idle cycle.
	assign commit = frame_end && frame_good;
	assign rewind = frame_end && !frame_good;

	assign frame_ok  = (state == VERDICT) && verdict_ok;
	assign frame_bad = (state == VERDICT) && !verdict_ok;

	assign crc_clear = (state == VERDICT);

	always_comb
	begin
		unique case (state)
			IDLE:
				state_next = in_valid ? RECEIVE : IDLE;
			RECEIVE:
				state_next = in_valid ? RECEIVE : VERDICT;
			VERDICT:
				state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge N_RST_DECODER)
	begin
		if (!N_RST_DECODER)
		begin
			state      <= IDLE;
			byte_cnt   <= '0;
			overflow   <= 1'b0;
			verdict_ok <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (crc_clear)
			begin
				byte_cnt <= '0;
				overflow <= 1'b0;
			end
			else
			begin
				// saturates so that a very long frame never looks short.
				if (accept && (byte_cnt != 8'hff))
					byte_cnt <= byte_cnt + 8'd1;
				if (kept && buf_full)
					overflow <= 1'b1;
			end
			if (frame_end)
				verdict_ok <= frame_good;
		end
	end

	crc8_atm_calc crc8_atm_calc_i
	(
		.clk           (clk),
		.N_RST_DECODER (N_RST_DECODER),
		.clear         (crc_clear),
		.en            (accept),
		.d             (in_data),
		.crc           (crc)
	);

endmodule

`default_nettype wire

// ==== hdl/rx_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer
(
	input  wire                 clk,
	input  wire                 N_RST_DECODER,
	input  wire                 wr_en,
	input  usb_rx_pkg::byte_t   wr_data,
	input  wire                 commit,
	input  wire                 rewind,
	input  wire                 rd_en,
	output logic                buf_full,
	output logic                avail,
	output usb_rx_pkg::byte_t   rd_data
);

	import usb_rx_pkg::*;

	byte_t mem [BUF_DEPTH];

	buf_addr_t  wr_ptr;
	buf_addr_t  cmt_ptr;
	buf_addr_t  rd_ptr;
	buf_addr_t  cmt_diff;
	buf_count_t count;
	buf_count_t count_base;
	buf_count_t count_next;
	buf_count_t cmt_count;
	logic       wr_acc;
	logic       rd_acc;

	assign buf_full = (count == BUF_DEPTH);
	assign avail    = (rd_ptr != cmt_ptr);

	assign wr_acc = wr_en && !buf_full;
	assign rd_acc = rd_en && avail;

	// the occupancy counts tentative bytes as well as committed ones.
	always_comb
	begin
		cmt_diff  = cmt_ptr - rd_ptr;
		cmt_count = {1'b0, cmt_diff};
		if (rewind)
			count_base = cmt_count;
		else if (commit)
			count_base = count - 7'd1;
		else
			count_base = count;
		count_next = count_base + buf_count_t'(wr_acc) - buf_count_t'(rd_acc);
	end

	always_ff @(posedge clk or negedge N_RST_DECODER)
	begin
		if (!N_RST_DECODER)
		begin
			wr_ptr  <= '0;
			cmt_ptr <= '0;
			rd_ptr  <= '0;
			count   <= '0;
		end
		else
		begin
			// commit leaves the crc byte outside the committed region.
			if (rewind)
				wr_ptr <= cmt_ptr;
			else if (commit)
			begin
				wr_ptr  <= wr_ptr - 6'd1;
				cmt_ptr <= wr_ptr - 6'd1;
			end
			else if (wr_acc)
				wr_ptr <= wr_ptr + 6'd1;
			if (rd_acc)
				rd_ptr <= rd_ptr + 6'd1;
			count <= count_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_acc)
			mem[wr_ptr] <= wr_data;
		if (rd_acc)
			rd_data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// ==== hdl/payload_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_streamer
#(
	parameter int MAX_CREDITS = 8
)
(
	input  wire                 clk,
	input  wire                 N_RST_DECODER,
	input  wire                 credit_return,
	input  wire                 avail,
	input  usb_rx_pkg::byte_t   rd_data,
	output logic                rd_en,
	output usb_rx_pkg::byte_t   q,
	output logic                q_valid
);

	localparam int CW = $clog2(MAX_CREDITS + 1);

	logic [CW-1:0] credits;
	logic [CW-1:0] spent;
	logic [CW-1:0] credits_next;

	// the read issued last cycle is in flight and still holds its credit.
	assign rd_en = avail && (credits > CW'(q_valid));

	// q comes from the buffer's read register, so it lines up with q_valid.
	assign q = rd_data;

	always_comb
	begin
		spent = credits - CW'(q_valid);
		if (credit_return && (spent < CW'(MAX_CREDITS)))
			credits_next = spent + 1'b1;
		else
			credits_next = spent;
	end

	always_ff @(posedge clk or negedge N_RST_DECODER)
	begin
		if (!N_RST_DECODER)
		begin
			credits <= '0;
			q_valid <= 1'b0;
		end
		else
		begin
			credits <= credits_next;
			q_valid <= rd_en;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/usb_rx_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_rx_subsystem
#(
	parameter int MAX_CREDITS = 8
)
(
	input  wire                 clk,
	input  wire                 N_RST_DECODER,
	input  wire                 in_valid,
	input  usb_rx_pkg::byte_t   in_data,
	input  wire                 credit_return,
	output usb_rx_pkg::byte_t   q,
	output logic                q_valid,
	output logic                frame_ok,
	output logic                frame_bad
);

	import usb_rx_pkg::*;

	logic  wr_en;
	byte_t wr_data;
	logic  commit;
	logic  rewind;
	logic  buf_full;
	logic  avail;
	logic  rd_en;
	byte_t rd_data;

	frame_decoder frame_decoder_i
	(
		.clk           (clk),
		.N_RST_DECODER (N_RST_DECODER),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.buf_full      (buf_full),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.commit        (commit),
		.rewind        (rewind),
		.frame_ok      (frame_ok),
		.frame_bad     (frame_bad)
	);

	rx_frame_buffer rx_frame_buffer_i
	(
		.clk           (clk),
		.N_RST_DECODER (N_RST_DECODER),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.commit        (commit),
		.rewind        (rewind),
		.rd_en         (rd_en),
		.buf_full      (buf_full),
		.avail         (avail),
		.rd_data       (rd_data)
	);

	payload_streamer
	#(
		.MAX_CREDITS (MAX_CREDITS)
	)
	payload_streamer_i
	(
		.clk           (clk),
		.N_RST_DECODER (N_RST_DECODER),
		.credit_return (credit_return),
		.avail         (avail),
		.rd_data       (rd_data),
		.rd_en         (rd_en),
		.q             (q),
		.q_valid       (q_valid)
	);

endmodule

`default_nettype wire

// ==== include/usb_rx_tb_model.svh ====
`ifndef USB_RX_TB_MODEL_SVH
`define USB_RX_TB_MODEL_SVH

// the frame being sent, byte 0 first.
byte_t frame_bytes [32];

// payload bytes in the order they must leave on q.
byte_t exp_q [$];

// one entry per frame sent, high for frame_ok.
logic  exp_verdict_q [$];

// credits the streamer holds, as seen from outside the DUT.
int    model_credits;

// crc-8/atm remainder over the first len bytes, msb first.
function automatic byte_t crc_of_bytes(input int len);
	byte_t c;
	int    i;
	int    b;
	c = 8'h00;
	for (i = 0; i < len; i++)
	begin
		c = c ^ frame_bytes[i];
		for (b = 0; b < 8; b++)
			c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
	end
	return c;
endfunction

// committed bytes plus the frame's kept bytes, crc included, must fit.
function automatic logic fits_in_buffer(input int len);
	return (exp_q.size() + len - 5) <= BUF_DEPTH;
endfunction

function automatic void predict_frame(input int len);
	logic good;
	int   i;
	good = (crc_of_bytes(len) == 8'h00) && (len >= MIN_FRAME_LEN) && fits_in_buffer(len);
	exp_verdict_q.push_back(good);
	if (good)
	begin
		exp_q.push_back(frame_bytes[2]);
		for (i = 6; i < len - 1; i++)
			exp_q.push_back(frame_bytes[i]);
	end
endfunction

function automatic void clear_model();
	exp_q.delete();
	exp_verdict_q.delete();
	model_credits = 0;
endfunction

`endif

// ==== verification/usb_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_rx_tb;

	import usb_rx_pkg::*;

	localparam int MAX_CREDITS = 8;

	logic        clk = 1'b0;
	logic        N_RST_DECODER;
	logic        in_valid;
	byte_t       in_data;
	logic        credit_return;
	byte_t       q;
	logic        q_valid;
	logic        frame_ok;
	logic        frame_bad;

	logic [31:0] rng_state = 32'h3bc2;
	int          credit_mode;
	int          burst_left;
	logic        burst_on;
	int unsigned cycle_count;
	int unsigned cycle_limit;
	int          verdicts_sent;
	int          verdicts_seen;
	int          n;
	logic        overflow;

	`include "usb_rx_tb_model.svh"

	usb_rx_subsystem
	#(
		.MAX_CREDITS (MAX_CREDITS)
	)
	usb_rx_subsystem_i
	(
		.clk           (clk),
		.N_RST_DECODER (N_RST_DECODER),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.credit_return (credit_return),
		.q             (q),
		.q_valid       (q_valid),
		.frame_ok      (frame_ok),
		.frame_bad     (frame_bad)
	);

	initial
	begin
		forever
			#5 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic int random_range(input int lo, input int hi);
		return lo + int'(next_random() % (hi - lo + 1));
	endfunction

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp);
		if (got !== exp)
			report_error($sformatf("q is %02h, expected %02h", got, exp));
	endtask

	task automatic check_verdict(input logic ok, input logic bad, input logic exp_good);
		if (ok === bad)
			report_error("frame_ok and frame_bad are high together");
		else if (ok !== exp_good)
			report_error($sformatf("verdict is %s, expected %s",
				ok ? "frame_ok" : "frame_bad", exp_good ? "frame_ok" : "frame_bad"));
	endtask

	// inputs change 1 ns after the rising edge, credits by the current mode.
	task automatic wait_cycle();
		@(posedge clk);
		#1;
		if (credit_mode == 1)
			credit_return = 1'b1;
		else if (credit_mode == 2)
		begin
			if (burst_left == 0)
			begin
				burst_on   = random_range(0, 1);
				burst_left = random_range(1, 8);
			end
			burst_left--;
			credit_return = burst_on;
		end
		else
			credit_return = 1'b0;
	endtask

	task automatic reset_dut();
		N_RST_DECODER = 1'b0;
		in_valid      = 1'b0;
		in_data       = 8'h00;
		credit_return = 1'b0;
		credit_mode   = 0;
		burst_left    = 0;
		clear_model();
		verdicts_sent = 0;
		verdicts_seen = 0;
		cycle_limit += 20;
		repeat (16)
			wait_cycle();
		N_RST_DECODER = 1'b1;
	endtask

	task automatic begin_test(input string name);
		$display("test: %s", name);
		cycle_limit += 64;
	endtask

	// a frame is followed by two idle cycles before its verdict is seen.
	task automatic send_frame(input int len, input logic corrupt);
		int i;
		int extra;
		frame_bytes[0] = 8'h80;
		for (i = 1; i < len - 1; i++)
			frame_bytes[i] = byte_t'(next_random());
		frame_bytes[len - 1] = crc_of_bytes(len - 1);
		if (corrupt)
			frame_bytes[len - 1] ^= byte_t'(random_range(1, 255));
		predict_frame(len);
		verdicts_sent++;
		extra = random_range(0, 2);
		cycle_limit += 2 * len + 2 + extra;
		for (i = 0; i < len; i++)
		begin
			in_valid = 1'b1;
			in_data  = frame_bytes[i];
			wait_cycle();
		end
		in_valid = 1'b0;
		in_data  = 8'h00;
		while (verdicts_seen < verdicts_sent)
			wait_cycle();
		repeat (extra)
			wait_cycle();
	endtask

	task automatic drain_output();
		credit_mode = 1;
		cycle_limit += 16;
		while (exp_q.size() > 0)
			wait_cycle();
		repeat (8)
			wait_cycle();
	endtask

	always @(negedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: the run hung and did not finish within %0d cycles", cycle_limit);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
		else if (N_RST_DECODER)
		begin
			if (frame_ok || frame_bad)
			begin
				if (exp_verdict_q.size() == 0)
					report_error("verdict pulse with no frame sent");
				else
					check_verdict(frame_ok, frame_bad, exp_verdict_q.pop_front());
				verdicts_seen++;
			end
			if (q_valid)
			begin
				if (model_credits == 0)
					report_error("q_valid with no credit left");
				else if (exp_q.size() == 0)
					report_error("byte on q with none expected");
				else
				begin
					check_byte(q, exp_q.pop_front());
					model_credits--;
				end
			end
			// a returned credit is lost while the count is saturated.
			if (credit_return)
			begin
				if (model_credits < MAX_CREDITS)
					model_credits++;
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		cycle_limit = 0;
		reset_dut();

		begin_test("state after reset");
		repeat (4)
		begin
			if ((q_valid !== 1'b0) || (frame_ok !== 1'b0) || (frame_bad !== 1'b0))
				report_error("outputs are not idle after reset");
			wait_cycle();
		end
		send_frame(random_range(7, 20), 1'b0);
		repeat (12)
			wait_cycle();

		begin_test("good frames");
		credit_mode = 1;
		repeat (10)
			send_frame(random_range(7, 20), 1'b0);
		drain_output();

		begin_test("corrupted crc");
		for (int i = 0; i < 8; i++)
			send_frame(random_range(7, 20), i[0]);
		drain_output();

		begin_test("short frames");
		for (int len = 1; len < MIN_FRAME_LEN; len++)
			send_frame(len, 1'b0);
		drain_output();

		reset_dut();
		begin_test("credit limit");
		credit_mode = 2;
		repeat (4)
			send_frame(random_range(7, 20), 1'b0);
		drain_output();

		reset_dut();
		begin_test("overflow");
		credit_mode = 0;
		overflow = 1'b0;
		while (!overflow)
		begin
			n = random_range(7, 20);
			overflow = !fits_in_buffer(n);
			send_frame(n, 1'b0);
		end
		drain_output();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/usb_rx_pkg.sv
hdl/crc8_atm_calc.sv
hdl/frame_decoder.sv
hdl/rx_frame_buffer.sv
hdl/payload_streamer.sv
hdl/usb_rx_subsystem.sv
verification/usb_rx_tb.sv
